// ==== pool_trace.txt ====
# Records: test <name> | wr <adr> <data> | rd <adr> <expected> | done | bp <0|1>
# idx <n> <index...> | win <n> <vector...> <expected max>, counts decimal, rest hex
test reg_access
rd 0 0001
rd 1 0000
wr 0 0004
rd 0 0004
wr 0 0000
rd 0 0001
wr 1 0055
rd 1 0000
# Twenty indices, more than the FIFO holds
test idx_order
idx 20 003 07f 1a2 000 0ff 155 2aa 011 3ff 100 0c3 222 05a 301 1e0 0a5 033 2f0 17c 0ee
# K of 4, lane 0 in the low byte
test max_pool
wr 0 0004
win 4 01020304 40302010 0a0b0c0d 11223344 40303344
win 4 ff000000 00ff0000 0000ff00 000000ff ffffffff
win 4 80808080 7f7f7f7f 81818181 00000000 81818181
win 4 10203040 10203040 10203040 10203040 10203040
# Output ready mostly low
test back_pressure
bp 1
win 4 05060708 08070605 01010101 02020202 08070708
win 4 aa000055 55aa0000 0055aa00 000055aa aaaaaaaa
win 4 12345678 87654321 11111111 09090909 87655678
win 4 fe01fe01 01fe01fe 7f7f7f7f 80808080 fefefefe
bp 0
# K of 1 passes vectors through, then K of 3
test k_change
wr 0 0001
win 1 deadbeef deadbeef
win 1 00000000 00000000
win 1 ffffffff ffffffff
win 1 0102a0b0 0102a0b0
wr 0 0003
rd 0 0003
win 3 10000000 00200000 00003000 10203000
win 3 c0c0c0c0 c1c0c0bf c0c1bfc0 c1c1c0c0
win 3 0f0e0d0c 0b0a0908 07060504 0f0e0d0c
test done_count
done

// ==== src.f ====
+incdir+.
pool_pkg.sv
pool_fifo.sv
pool_max_core.sv
pool_lane_ctrl.sv
pool_wb_cfg.sv
pool_top.sv
tb_clk_gen.sv
pool_chk.sv
pool_tb.sv

// ==== Bender.yml ====
package:
  name: pool_lane_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pool_pkg.sv
      - pool_fifo.sv
      - pool_max_core.sv
      - pool_lane_ctrl.sv
      - pool_wb_cfg.sv
      - pool_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - pool_chk.sv
      - pool_tb.sv

// ==== pool_tb.sv ====
// Trace-driven testbench for the pooling lane controller
// Memory model behind the address port, pooled vector scoreboard,
// LFSR ready randomization and a cycle timeout

`include "pool_defs.svh"

module pool_tb;

    localparam int IW = `POOL_IDX_WIDTH;

    logic               clk;
    logic               rst_n;
    logic               wb_cyc, wb_stb, wb_we, wb_adr, wb_ack;
    logic [15:0]        wb_dat_i, wb_dat_o;
    logic               idx_valid, idx_ready, addr_valid, addr_ready;
    pool_pkg::idx_t     idx, addr;
    logic               ofm_in_valid, ofm_in_ready, ofm_out_valid, ofm_out_ready;
    pool_pkg::act_vec_t ofm_in, ofm_out;

    // ====================
    // Scoreboard state
    // ====================
    pool_pkg::idx_t     idx_q[$];
    // Top bit set when the address fetches a window vector
    logic [IW:0]        exp_addr_q[$];
    pool_pkg::act_vec_t act_q[$];
    pool_pkg::act_vec_t exp_out_q[$];
    pool_pkg::act_vec_t mem [0:(1<<IW)-1];
    logic [31:0]        lfsr;
    logic [8*32-1:0]    test_name;
    logic               in_test, bp_on;
    int                 tests, checks, errors, test_checks, test_errors;
    int                 out_cnt, cycles, limit;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    pool_top uut (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .idx_valid(idx_valid), .idx(idx), .idx_ready(idx_ready),
        .addr_valid(addr_valid), .addr(addr), .addr_ready(addr_ready),
        .ofm_in_valid(ofm_in_valid), .ofm_in(ofm_in), .ofm_in_ready(ofm_in_ready),
        .ofm_out_valid(ofm_out_valid), .ofm_out(ofm_out), .ofm_out_ready(ofm_out_ready)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        test_errors++;
        $display("mismatch test %0s, %0s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic report_error(input string msg);
        errors++;
        test_errors++;
        $display("test %0s: %0s", test_name, msg);
    endtask

    // Compare one sampled output with its expected value
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            report_mismatch(what, exp, act);
        end
    endtask

    // Wait until every queued index, fetch and window is through
    task automatic drain_queues();
        while (idx_q.size() || exp_addr_q.size() || act_q.size() || exp_out_q.size()) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test();
        drain_queues();
        if (in_test) begin
            tests++;
            if (test_errors == 0) begin
                $display("test %0s: ok, %0d checks", test_name, test_checks);
            end else begin
                $display("test %0s: %0d of %0d checks failed", test_name, test_errors,
                         test_checks);
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // One classic cycle that ends with ack
    task automatic wb_access(input logic we, input logic adr, input logic [15:0] wdat,
                             output logic [15:0] rdat);
        drain_queues();
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdat;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdat   = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // ====================
    // Drivers on the falling edge
    // ====================
    always @(negedge clk) begin
        logic r0;
        logic r1;
        addr_ready = rand_bit();
        r0 = rand_bit();
        // Back-pressure mode leaves output ready high a quarter of the time
        if (bp_on) begin
            r1 = rand_bit();
            ofm_out_ready = r0 && r1;
        end else begin
            ofm_out_ready = r0;
        end
        idx_valid = (idx_q.size() != 0);
        if (idx_valid) begin
            idx = idx_q[0];
        end
        ofm_in_valid = (act_q.size() != 0);
        if (ofm_in_valid) begin
            ofm_in = act_q[0];
        end
    end

    // ====================
    // Monitor on the rising edge
    // ====================
    always @(posedge clk) begin
        logic [IW:0] e;
        if (rst_n) begin
            if (idx_valid && idx_ready) begin
                void'(idx_q.pop_front());
            end
            if (ofm_in_valid && ofm_in_ready) begin
                void'(act_q.pop_front());
            end
            if (addr_valid && addr_ready) begin
                if (exp_addr_q.size() == 0) begin
                    report_error("an address came out with none pending");
                end else begin
                    e = exp_addr_q.pop_front();
                    checks++;
                    test_checks++;
                    if (addr !== e[IW-1:0]) begin
                        report_mismatch("addr", e[IW-1:0], addr);
                    end
                    // Memory model answers with the stored vector
                    if (e[IW]) begin
                        act_q.push_back(mem[addr]);
                    end
                end
            end
            if (ofm_out_valid && ofm_out_ready) begin
                out_cnt++;
                if (exp_out_q.size() == 0) begin
                    report_error("a pooled vector came out with none expected");
                end else begin
                    checks++;
                    test_checks++;
                    if (ofm_out !== exp_out_q[0]) begin
                        report_mismatch("ofm_out", exp_out_q[0], ofm_out);
                    end
                    void'(exp_out_q.pop_front());
                end
            end
        end
    end

    // Limit grows by 200 cycles per trace record
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ====================
    // Trace reader
    // ====================
    initial begin
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] line;
        logic [31:0]      a;
        logic [31:0]      v;
        logic [15:0]      rdat;
        pool_pkg::idx_t   base;
        int               fd;
        int               n;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 1'b0;
        wb_dat_i = '0;
        idx_valid = 1'b0;
        idx = '0;
        addr_ready = 1'b0;
        ofm_in_valid = 1'b0;
        ofm_in = '0;
        ofm_out_ready = 1'b0;
        lfsr = 32'h8697;
        bp_on = 1'b0;
        in_test = 1'b0;
        tests = 0;
        checks = 0;
        errors = 0;
        test_checks = 0;
        test_errors = 0;
        out_cnt = 0;
        cycles = 0;
        limit = 100;
        // Window vectors live in the upper half of memory
        base = IW'(1 << (IW - 1));
        fd = $fopen("pool_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file pool_trace.txt");
            errors++;
        end
        wait (rst_n === 1'b1);
        // Handshake outputs straight out of reset
        test_name = "reset";
        in_test = 1'b1;
        check_value("addr_valid", 32'd0, addr_valid);
        check_value("ofm_out_valid", 32'd0, ofm_out_valid);
        check_value("wb_ack", 32'd0, wb_ack);
        check_value("idx_ready", 32'd1, idx_ready);
        check_value("ofm_in_ready", 32'd1, ofm_in_ready);
        @(posedge clk);
        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            limit += 200;
            if (cmd == "#") begin
                void'($fgets(line, fd));
            end else if (cmd == "test") begin
                finish_test();
                void'($fscanf(fd, "%s", test_name));
                in_test = 1'b1;
            end else if (cmd == "wr") begin
                void'($fscanf(fd, "%h %h", a, v));
                wb_access(1'b1, a[0], v[15:0], rdat);
            end else if (cmd == "rd") begin
                void'($fscanf(fd, "%h %h", a, v));
                wb_access(1'b0, a[0], 16'h0, rdat);
                checks++;
                test_checks++;
                if (rdat !== v[15:0]) begin
                    report_mismatch("register read", v[15:0], rdat);
                end
            end else if (cmd == "done") begin
                wb_access(1'b0, pool_pkg::REG_DONE, 16'h0, rdat);
                checks++;
                test_checks++;
                if (rdat !== out_cnt[15:0]) begin
                    report_mismatch("done count", out_cnt[15:0], rdat);
                end
            end else if (cmd == "bp") begin
                void'($fscanf(fd, "%h", a));
                @(posedge clk);
                bp_on = a[0];
            end else if (cmd == "idx") begin
                void'($fscanf(fd, "%d", n));
                @(posedge clk);
                for (int i = 0; i < n; i++) begin
                    void'($fscanf(fd, "%h", a));
                    idx_q.push_back(a[IW-1:0]);
                    exp_addr_q.push_back({1'b0, a[IW-1:0]});
                end
            end else if (cmd == "win") begin
                void'($fscanf(fd, "%d", n));
                @(posedge clk);
                for (int i = 0; i < n; i++) begin
                    void'($fscanf(fd, "%h", v));
                    mem[base] = v;
                    idx_q.push_back(base);
                    exp_addr_q.push_back({1'b1, base});
                    base = base + 1'b1;
                end
                void'($fscanf(fd, "%h", v));
                exp_out_q.push_back(v);
            end else begin
                report_error("the trace holds an unknown record");
            end
        end
        finish_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== pool_chk.sv ====
// Bound assertions for the pooling lane controller
// Output handshake stability, Wishbone ack spacing, index FIFO rules

`include "pool_defs.svh"

module pool_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               idx_valid,
    input logic               idx_ready,
    input logic               addr_valid,
    input logic               addr_ready,
    input pool_pkg::idx_t     addr,
    input logic               ofm_out_valid,
    input logic               ofm_out_ready,
    input pool_pkg::act_vec_t ofm_out,
    input logic               wb_ack
);

    localparam int DEPTH = 1 << `POOL_FIFO_AW;

    // Entries held as counted from the two index handshakes
    logic [`POOL_FIFO_AW:0] occ;
    logic                   push;
    logic                   pop;

    assign push = idx_valid && idx_ready;
    assign pop  = addr_valid && addr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ <= '0;
        end else if (push && !pop) begin
            occ <= occ + 1'b1;
        end else if (pop && !push) begin
            occ <= occ - 1'b1;
        end
    end

    // ====================
    // Stream outputs
    // ====================
    // Stalled address stays put
    addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (addr_valid && !addr_ready) |=> (addr_valid && $stable(addr)))
        else $error("address valid or data changed while stalled");

    // Stalled pooled vector stays put
    ofm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ofm_out_valid && !ofm_out_ready) |=> (ofm_out_valid && $stable(ofm_out)))
        else $error("pooled valid or data changed while stalled");

    // ====================
    // Bus and FIFO
    // ====================
    ack_gap: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else $error("wb_ack high on two cycles in a row");

    // Index accepted with all entries already taken
    no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && (occ == DEPTH)))
        else $error("index FIFO pushed while full");

    // Address handed out with nothing held
    no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && (occ == 0)))
        else $error("index FIFO popped while empty");

endmodule

bind pool_top pool_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .idx_valid     (idx_valid),
    .idx_ready     (idx_ready),
    .addr_valid    (addr_valid),
    .addr_ready    (addr_ready),
    .addr          (addr),
    .ofm_out_valid (ofm_out_valid),
    .ofm_out_ready (ofm_out_ready),
    .ofm_out       (ofm_out),
    .wb_ack        (wb_ack)
);

// ==== tb_clk_gen.sv ====
// Testbench clock and reset generator
// Clock period of 40, reset held low for the first 4 cycles

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Released on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== pool_top.sv ====
// Pooling lane controller top level
// Wishbone configuration slave plus lane controller

`include "pool_defs.svh"

module pool_top (
    input  logic                clk,
    input  logic                rst_n,
    // Wishbone classic
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic                wb_adr,
    input  logic [15:0]         wb_dat_i,
    output logic [15:0]         wb_dat_o,
    output logic                wb_ack,
    // Index stream
    input  logic                idx_valid,
    input  pool_pkg::idx_t      idx,
    output logic                idx_ready,
    // Memory read address
    output logic                addr_valid,
    output pool_pkg::idx_t      addr,
    input  logic                addr_ready,
    // Activations in
    input  logic                ofm_in_valid,
    input  pool_pkg::act_vec_t  ofm_in,
    output logic                ofm_in_ready,
    // Pooled vectors out
    output logic                ofm_out_valid,
    output pool_pkg::act_vec_t  ofm_out,
    input  logic                ofm_out_ready
);

    // ====================
    // Internal wires
    // ====================
    logic [`POOL_K_WIDTH-1:0] cfg_k;
    logic                     window_done;

    // Register block
    pool_wb_cfg u_wb_cfg (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack),
        .window_done (window_done),
        .cfg_k       (cfg_k)
    );

    // Index and data paths
    pool_lane_ctrl u_lane_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_k         (cfg_k),
        .idx_valid     (idx_valid),
        .idx           (idx),
        .idx_ready     (idx_ready),
        .addr_valid    (addr_valid),
        .addr          (addr),
        .addr_ready    (addr_ready),
        .ofm_in_valid  (ofm_in_valid),
        .ofm_in        (ofm_in),
        .ofm_in_ready  (ofm_in_ready),
        .ofm_out_valid (ofm_out_valid),
        .ofm_out       (ofm_out),
        .ofm_out_ready (ofm_out_ready),
        .window_done   (window_done)
    );

endmodule

// ==== pool_wb_cfg.sv ====
// Wishbone classic configuration slave
// Window size register K and 16-bit count of finished windows

`include "pool_defs.svh"

module pool_wb_cfg (
    input  logic                     clk,
    input  logic                     rst_n,
    // Wishbone classic
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic                     wb_adr,
    input  logic [15:0]              wb_dat_i,
    output logic [15:0]              wb_dat_o,
    output logic                     wb_ack,
    // Lane controller side
    input  logic                     window_done,
    output logic [`POOL_K_WIDTH-1:0] cfg_k
);

    localparam int KW = `POOL_K_WIDTH;
    localparam int DW = 16;

    // ====================
    // Bus decode
    // ====================
    pool_pkg::reg_addr_e reg_sel;
    logic                req;
    logic [KW-1:0]       wr_k;
    logic [DW-1:0]       done_cnt;

    assign reg_sel = pool_pkg::reg_addr_e'(wb_adr);
    // New access only while ack is low, so ack never repeats back to back
    assign req     = wb_cyc && wb_stb && !wb_ack;
    // K of zero makes no window, stored as one
    assign wr_k    = (wb_dat_i[KW-1:0] == '0) ? KW'(1) : wb_dat_i[KW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            cfg_k    <= KW'(1);
            done_cnt <= '0;
        end else begin
            wb_ack <= req;
            // Writes to DONE fall through
            if (req && wb_we && (reg_sel == pool_pkg::REG_K)) begin
                cfg_k <= wr_k;
            end
            // Wraps at 2^16
            if (window_done) begin
                done_cnt <= done_cnt + 1'b1;
            end
        end
    end

    // Read data lands with ack
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            case (reg_sel)
                pool_pkg::REG_K:    wb_dat_o <= {{(DW-KW){1'b0}}, cfg_k};
                pool_pkg::REG_DONE: wb_dat_o <= done_cnt;
                default:            wb_dat_o <= '0;
            endcase
        end
    end

endmodule

// ==== pool_lane_ctrl.sv ====
// Pooling lane controller
// Index FIFO toward memory, window beat counter, lane-wise max core
// Pulses window_done on every pooled vector handed out

`include "pool_defs.svh"

module pool_lane_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`POOL_K_WIDTH-1:0]   cfg_k,
    // Index stream in
    input  logic                       idx_valid,
    input  pool_pkg::idx_t             idx,
    output logic                       idx_ready,
    // Read address out
    output logic                       addr_valid,
    output pool_pkg::idx_t             addr,
    input  logic                       addr_ready,
    // Activations from memory
    input  logic                       ofm_in_valid,
    input  pool_pkg::act_vec_t         ofm_in,
    output logic                       ofm_in_ready,
    // Pooled vectors
    output logic                       ofm_out_valid,
    output pool_pkg::act_vec_t         ofm_out,
    input  logic                       ofm_out_ready,
    output logic                       window_done
);

    localparam int KW = `POOL_K_WIDTH;

    // ====================
    // Index path
    // ====================
    logic fifo_empty;
    logic fifo_full;

    pool_fifo #(
        .T        (pool_pkg::idx_t)
    ) u_idx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (idx_valid && idx_ready),
        .pop      (addr_valid && addr_ready),
        .data_in  (idx),
        .data_out (addr),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    // Ready from FIFO state only
    assign idx_ready  = !fifo_full;
    assign addr_valid = !fifo_empty;

    // ====================
    // Window counter
    // ====================
    logic [KW-1:0] beat_cnt;
    logic [KW-1:0] k_cap;
    logic [KW-1:0] k_eff;
    logic [KW-1:0] last_cnt;
    logic          beat_acc;
    logic          in_last;

    assign beat_acc = ofm_in_valid && ofm_in_ready;

    // At window start the live K applies, later the captured one
    assign k_eff    = (beat_cnt == '0) ? cfg_k : k_cap;
    assign last_cnt = k_eff - 1'b1;
    // Wrap of the counter marks the K-th beat
    assign in_last  = (beat_cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            k_cap    <= KW'(1);
        end else if (beat_acc) begin
            if (beat_cnt == '0) begin
                k_cap <= cfg_k;
            end
            if (in_last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // ====================
    // Max core
    // ====================
    pool_max_core u_max_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ofm_in_valid),
        .in_last   (in_last),
        .in_data   (ofm_in),
        .in_ready  (ofm_in_ready),
        .out_valid (ofm_out_valid),
        .out_data  (ofm_out),
        .out_ready (ofm_out_ready)
    );

    // One pulse per output transfer
    assign window_done = ofm_out_valid && ofm_out_ready;

endmodule

// ==== pool_max_core.sv ====
// Lane-wise running maximum over one pooling window
// Unsigned compare per lane, one-entry output register with valid/ready

`include "pool_defs.svh"

module pool_max_core (
    input  logic                clk,
    input  logic                rst_n,
    // Activation beats
    input  logic                in_valid,
    input  logic                in_last,
    input  pool_pkg::act_vec_t  in_data,
    output logic                in_ready,
    // Pooled vector
    output logic                out_valid,
    output pool_pkg::act_vec_t  out_data,
    input  logic                out_ready
);

    // ====================
    // Window state
    // ====================
    // High until the first beat of a window is taken
    logic               first;
    pool_pkg::act_vec_t run_max;
    pool_pkg::act_vec_t next_max;
    logic               in_acc;

    // Stall only when result is stuck in the output register
    assign in_ready = !out_valid || out_ready;
    assign in_acc   = in_valid && in_ready;

    // First beat loads as is, later beats compare per lane
    always_comb begin
        for (int i = 0; i < `POOL_LANES; i++) begin
            if (first || (in_data[i] > run_max[i])) begin
                next_max[i] = in_data[i];
            end else begin
                next_max[i] = run_max[i];
            end
        end
    end

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first     <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            // Last beat restarts the window
            if (in_acc) begin
                first <= in_last;
            end
            // Load wins over drain in the same cycle
            if (in_acc && in_last) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Running value and result payload
    always_ff @(posedge clk) begin
        if (in_acc && !in_last) begin
            run_max <= next_max;
        end
        if (in_acc && in_last) begin
            out_data <= next_max;
        end
    end

endmodule

// ==== pool_fifo.sv ====
// First-word-fall-through FIFO with a type parameter for the payload
// Circular buffer, one-bit-extended pointers, combinational head word

`include "pool_defs.svh"

module pool_fifo #(
    parameter type T = pool_pkg::idx_t
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  logic pop,
    input  T     data_in,
    output T     data_out,
    output logic empty,
    output logic full
);

    localparam int AW    = `POOL_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    // ====================
    // Storage and pointers
    // ====================
    T mem [0:DEPTH-1];

    // Extra MSB tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic push_ok;
    logic pop_ok;

    // Requests outside legal state are dropped
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // Same slot, same lap
    assign empty = (wr_ptr == rd_ptr);
    // Same slot, write one lap ahead
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Head word shows up with empty low
    assign data_out = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[AW-1:0]] <= data_in;
        end
    end

endmodule

// ==== pool_pkg.sv ====
// Shared types for the pooling lane controller
// Index word, activation vector and Wishbone register map

`include "pool_defs.svh"

package pool_pkg;

    // Index word, also used as memory read address
    typedef logic [`POOL_IDX_WIDTH-1:0] idx_t;

    // Single unsigned activation
    typedef logic [`POOL_ACT_WIDTH-1:0] act_t;

    // Packed vector, lane 0 in the low bits
    typedef act_t [`POOL_LANES-1:0] act_vec_t;

    // ====================
    // Register map
    // ====================
    // Word addressed, one address bit
    typedef enum logic [0:0] {
        REG_K    = 1'b0,   // Window size, read/write
        REG_DONE = 1'b1    // Finished windows mod 2^16, read only
    } reg_addr_e;

endpackage

// ==== pool_defs.svh ====
// Shared sizing macros for the pooling lane controller
// Index width, activation width, lane count, window size width, FIFO depth

`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// ====================
// Index path
// ====================
// Feature-map index and read address width
`define POOL_IDX_WIDTH 10
// Index FIFO address bits, 16 entries
`define POOL_FIFO_AW 4

// ====================
// Data path
// ====================
// One unsigned activation
`define POOL_ACT_WIDTH 8
// Parallel lanes per vector
`define POOL_LANES 4
// Window size K, 1 to 31
`define POOL_K_WIDTH 5

`endif
